//--- verilog/fp16_pkg.sv
`default_nettype none

package fp16_pkg;

	// ==========================================================
	// binary16 field layout
	// ==========================================================

	// top bit index of the 5-bit exponent field
	localparam int fp16_emsb = 4;
	// top bit index of the 10-bit fraction field
	localparam int fp16_fmsb = 9;

	// one half-precision word
	// bit 15 sign, bits 14..10 biased exponent, bits 9..0 fraction
	typedef logic [fp16_emsb+fp16_fmsb+2:0] fp16_t;

	// canonical quiet nan
	// exponent all ones, fraction msb set, sign clear
	localparam fp16_t fp16_qnan = 16'h7e00;

	// ==========================================================
	// opcodes
	// ==========================================================

	// one opcode per issued operand pair
	typedef enum logic [2:0]
	{
		// full 16-bit predicate vector
		op_cmp = 3'd0,
		// single-bit equal
		op_eq  = 3'd1,
		// single-bit less than
		op_lt  = 3'd2,
		// single-bit less or equal
		op_le  = 3'd3,
		// single-bit unordered
		op_un  = 3'd4,
		// ieee minNum
		op_min = 3'd5,
		// ieee maxNum
		op_max = 3'd6
	} fp16_op_e;

	// ==========================================================
	// predicate vector bit positions
	// ==========================================================

	// bits 5..7 and 13..15 read as zero
	// bits 8..12 hold the complements of bits 0..4
	localparam int cmp_bit_eq    = 0;
	localparam int cmp_bit_lt    = 1;
	localparam int cmp_bit_le    = 2;
	// magnitude only, sign ignored
	localparam int cmp_bit_ltmag = 3;
	localparam int cmp_bit_un    = 4;

endpackage

`default_nettype wire

//--- verilog/fp16_decomp.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_decomp
(
	input  fp16_pkg::fp16_t              i,
	output logic                         sgn,
	output logic [fp16_pkg::fp16_emsb:0] exp,
	output logic [fp16_pkg::fp16_fmsb:0] man,
	output logic                         vz,
	output logic                         nan,
	output logic                         qnan,
	output logic                         snan
);
	import fp16_pkg::*;

	// exponent field is all ones, so inf or nan
	logic exp_ones;
	// exponent field is all zeros, so zero or subnormal
	logic exp_zero;
	// any fraction bit set
	logic man_nz;

	// ==========================================================
	// field extraction
	// ==========================================================

	// sign sits above exponent and fraction
	assign sgn = i[fp16_emsb+fp16_fmsb+2];
	// exponent directly above the fraction
	assign exp = i[fp16_fmsb+1 +: fp16_emsb+1];
	assign man = i[fp16_fmsb:0];

	// ==========================================================
	// classification
	// ==========================================================

	assign exp_ones = &exp;
	assign exp_zero = ~|exp;
	assign man_nz   = |man;

	// zero of either sign, subnormals are not zero here
	assign vz = exp_zero & ~man_nz;

	// all-ones exponent with a nonzero fraction
	assign nan = exp_ones & man_nz;

	// fraction msb picks quiet versus signaling
	assign qnan = nan & man[fp16_fmsb];
	assign snan = nan & ~man[fp16_fmsb];

endmodule

`default_nettype wire

//--- verilog/fp16_compare.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_compare
(
	input  fp16_pkg::fp16_t a,
	input  fp16_pkg::fp16_t b,
	output logic [15:0]     pred,
	output logic            lt,
	output logic            eq,
	output logic            a_nan,
	output logic            b_nan,
	output logic            nan,
	output logic            snan
);
	import fp16_pkg::*;

	// decomposed operand a
	logic                sa;
	logic [fp16_emsb:0]  xa;
	logic [fp16_fmsb:0]  ma;
	logic                az;
	logic                a_snan;

	// decomposed operand b
	logic                sb;
	logic [fp16_emsb:0]  xb;
	logic [fp16_fmsb:0]  mb;
	logic                bz;
	logic                b_snan;

	// either operand is a nan
	logic unordered;
	// magnitude comparisons on exponent and fraction together
	logic mag_lt;
	logic mag_gt;
	// +0 against -0 counts as both zero
	logic both_zero;
	// signed less-than before nan gating
	logic lt_raw;

	// ==========================================================
	// operand decomposition
	// ==========================================================

	// quiet class not needed here, only nan and snan
	fp16_decomp i_decomp_a
	(
		.i    (a),
		.sgn  (sa),
		.exp  (xa),
		.man  (ma),
		.vz   (az),
		.nan  (a_nan),
		.qnan (),
		.snan (a_snan)
	);

	fp16_decomp i_decomp_b
	(
		.i    (b),
		.sgn  (sb),
		.exp  (xb),
		.man  (mb),
		.vz   (bz),
		.nan  (b_nan),
		.qnan (),
		.snan (b_snan)
	);

	// ==========================================================
	// ordering
	// ==========================================================

	assign unordered = a_nan | b_nan;
	assign both_zero = az & bz;

	// biased exponent then fraction orders magnitude as plain unsigned
	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// different signs mean the negative one is smaller, unless +0/-0
	// same negative sign flips the magnitude test
	assign lt_raw = (sa ^ sb) ? (sa & ~both_zero) : (sa ? mag_gt : mag_lt);

	// nothing is ordered against a nan
	assign lt = ~unordered & lt_raw;
	assign eq = ~unordered & (both_zero | (a == b));

	// ==========================================================
	// predicate vector
	// ==========================================================

	always_comb
	begin
		pred = '0;
		pred[cmp_bit_eq]    = eq;
		pred[cmp_bit_lt]    = lt;
		pred[cmp_bit_le]    = lt | eq;
		pred[cmp_bit_ltmag] = mag_lt;
		pred[cmp_bit_un]    = unordered;
		// upper byte carries the complements
		pred[8+cmp_bit_eq]    = ~eq;
		pred[8+cmp_bit_lt]    = ~lt;
		pred[8+cmp_bit_le]    = ~(lt | eq);
		pred[8+cmp_bit_ltmag] = ~mag_lt;
		pred[8+cmp_bit_un]    = ~unordered;
	end

	// exception flags, snan raised whatever the op
	assign nan  = unordered;
	assign snan = a_snan | b_snan;

	// an operand pair can never be both equal and less
	a_eq_lt_exclusive: assert final (!(eq && lt))
		else $error("fp16_compare eq and lt both high for %h %h", a, b);

endmodule

`default_nettype wire

//--- verilog/fp16_minmax.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_minmax
(
	input  fp16_pkg::fp16_t a,
	input  fp16_pkg::fp16_t b,
	input  logic            lt,
	input  logic            a_nan,
	input  logic            b_nan,
	input  logic            sel_max,
	output fp16_pkg::fp16_t res
);
	import fp16_pkg::*;

	// sign bits of both operands
	logic a_sgn;
	logic b_sgn;
	// +0 and -0 compare equal but are told apart by sign
	logic both_zero;
	// ordered pick before nan handling
	fp16_t ord_min;
	fp16_t ord_max;

	// ==========================================================
	// ordered selection
	// ==========================================================

	assign a_sgn = a[fp16_emsb+fp16_fmsb+2];
	assign b_sgn = b[fp16_emsb+fp16_fmsb+2];

	// magnitude bits all clear on both sides
	assign both_zero = ~|a[fp16_emsb+fp16_fmsb+1:0] & ~|b[fp16_emsb+fp16_fmsb+1:0];

	always_comb
	begin
		if (both_zero)
		begin
			// min prefers the negative zero, max the positive one
			ord_min = a_sgn ? a : b;
			ord_max = a_sgn ? b : a;
		end
		else
		begin
			// identical words land here too, either pick is the same value
			ord_min = lt ? a : b;
			ord_max = lt ? b : a;
		end
	end

	// ==========================================================
	// nan rules
	// ==========================================================

	always_comb
	begin
		if (a_nan & b_nan)
			res = fp16_qnan;
		else if (a_nan)
			// a single nan yields the numeric operand
			res = b;
		else if (b_nan)
			res = a;
		else
			res = sel_max ? ord_max : ord_min;
	end

	// never invents a value other than an input or the canonical nan
	a_res_source: assert final (res == a || res == b || res == fp16_qnan)
		else $error("fp16_minmax result %h not from %h %h", res, a, b);

endmodule

`default_nettype wire

//--- verilog/fp16_cmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_cmp_unit
(
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  fp16_pkg::fp16_op_e  op,
	input  fp16_pkg::fp16_t     a,
	input  fp16_pkg::fp16_t     b,
	output logic                out_valid,
	output logic [15:0]         result,
	output logic                nan,
	output logic                snan
);
	import fp16_pkg::*;

	// stage 1 registers
	logic      s1_valid;
	fp16_op_e  s1_op;
	fp16_t     s1_a;
	fp16_t     s1_b;

	// compare outputs
	logic [15:0] cmp_pred;
	logic        cmp_lt;
	logic        cmp_a_nan;
	logic        cmp_b_nan;
	logic        cmp_nan;
	logic        cmp_snan;

	// minmax path
	logic   sel_max;
	fp16_t  mm_res;

	// result selected by opcode, ahead of the stage 2 register
	logic [15:0] mux_res;

	// ==========================================================
	// stage 1 operand register
	// ==========================================================

	// valid bit is the only control state
	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// payload follows the strobe, no enable needed
	always_ff @(posedge clk)
	begin
		s1_op <= op;
		s1_a  <= a;
		s1_b  <= b;
	end

	// ==========================================================
	// combinational compare and select
	// ==========================================================

	// eq is already folded into the predicate vector
	fp16_compare i_fp16_compare
	(
		.a     (s1_a),
		.b     (s1_b),
		.pred  (cmp_pred),
		.lt    (cmp_lt),
		.eq    (),
		.a_nan (cmp_a_nan),
		.b_nan (cmp_b_nan),
		.nan   (cmp_nan),
		.snan  (cmp_snan)
	);

	// max only for op_max, every other op sees min
	assign sel_max = (s1_op == op_max);

	// reuses the compare nan decode
	fp16_minmax i_fp16_minmax
	(
		.a       (s1_a),
		.b       (s1_b),
		.lt      (cmp_lt),
		.a_nan   (cmp_a_nan),
		.b_nan   (cmp_b_nan),
		.sel_max (sel_max),
		.res     (mm_res)
	);

	// ==========================================================
	// result multiplexer
	// ==========================================================

	always_comb
	begin
		case (s1_op)
			op_cmp:  mux_res = cmp_pred;
			// single-bit ops land in bit 0
			op_eq:   mux_res = {15'd0, cmp_pred[cmp_bit_eq]};
			op_lt:   mux_res = {15'd0, cmp_pred[cmp_bit_lt]};
			op_le:   mux_res = {15'd0, cmp_pred[cmp_bit_le]};
			op_un:   mux_res = {15'd0, cmp_pred[cmp_bit_un]};
			op_min:  mux_res = mm_res;
			op_max:  mux_res = mm_res;
			// unused encoding 7
			default: mux_res = '0;
		endcase
	end

	// ==========================================================
	// stage 2 output register
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= s1_valid;
	end

	// flags go out for every op, matching the result they travel with
	always_ff @(posedge clk)
	begin
		result <= mux_res;
		nan    <= cmp_nan;
		snan   <= cmp_snan;
	end

	// output strobe is quiet right after reset
	a_reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

endmodule

`default_nettype wire

//--- dv/fp16_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_clk_gen
(
	output logic clk,
	output logic reset
);

	// free running clock, 8 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// reset spans the first three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/tb_fp16_cmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp16_cmp_unit;
	import fp16_pkg::*;

	// words per vector row: valid op a b result nan snan
	localparam int row_words = 7;
	// upper bound on rows in the vector file
	localparam int max_rows = 64;
	localparam int clk_period_ns = 8;

	logic        clk;
	logic        reset;
	logic        in_valid;
	fp16_op_e    op;
	fp16_t       a;
	fp16_t       b;
	logic        out_valid;
	logic [15:0] result;
	logic        nan;
	logic        snan;

	// raw vector words, unused tail stays x
	logic [15:0] vec_mem [0:row_words*max_rows-1];
	int          num_rows;
	// falling edges seen since reset was released
	int          neg_count;

	// expected outputs in issue order
	logic [15:0] exp_res_q [$];
	logic        exp_nan_q [$];
	logic        exp_snan_q [$];
	fp16_op_e    exp_op_q [$];
	// falling edge at which each output is due
	int          due_q [$];

	fp16_clk_gen i_fp16_clk_gen
	(
		.clk   (clk),
		.reset (reset)
	);

	fp16_cmp_unit i_fp16_cmp_unit
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.nan       (nan),
		.snan      (snan)
	);

	// ==========================================================
	// checking helpers
	// ==========================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_result(input logic [15:0] got, input logic [15:0] want,
		input fp16_op_e code);
		if (got !== want)
			fail_run($sformatf("ERROR result (%s): got %h, expected %h",
				code.name(), got, want));
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
			fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, want));
	endtask

	// ==========================================================
	// stimulus
	// ==========================================================

	initial
	begin
		int base;
		int rows;
		in_valid <= 1'b0;
		op       <= op_cmp;
		a        <= '0;
		b        <= '0;
		$readmemh("dv/fp16_cmp_input.txt", vec_mem);
		// rows end at the first unfilled valid column
		rows = 0;
		while (rows < max_rows && !$isunknown(vec_mem[row_words*rows]))
			rows++;
		// watchdog sizes itself from this count
		num_rows = rows;
		if (num_rows == 0)
			fail_run("no vectors could be read from dv/fp16_cmp_input.txt");
		else
		begin
			@(negedge reset);
			for (int i = 0; i < num_rows; i++)
			begin
				@(posedge clk);
				base = row_words * i;
				in_valid <= vec_mem[base][0];
				op       <= fp16_op_e'(vec_mem[base+1][2:0]);
				a        <= vec_mem[base+2];
				b        <= vec_mem[base+3];
				// idle rows expect nothing back
				if (vec_mem[base][0])
				begin
					exp_res_q.push_back(vec_mem[base+4]);
					exp_nan_q.push_back(vec_mem[base+5][0]);
					exp_snan_q.push_back(vec_mem[base+6][0]);
					exp_op_q.push_back(fp16_op_e'(vec_mem[base+1][2:0]));
					// captured next edge, out_valid set one edge later
					due_q.push_back(neg_count + 3);
				end
			end
			@(posedge clk);
			in_valid <= 1'b0;
			// drain both stages, then one more edge past the last due slot
			repeat (3) @(negedge clk);
			@(posedge clk);
			if (due_q.size() != 0)
				fail_run($sformatf("%0d issued operations never came out", due_q.size()));
			else
			begin
				$display("NO ERRORS");
				$finish;
			end
		end
	end

	// ==========================================================
	// output monitor
	// ==========================================================

	// outputs settle on the rising edge, so look at the falling one
	initial
	begin
		neg_count = 0;
		@(negedge reset);
		forever
		begin
			@(negedge clk);
			neg_count++;
			if (out_valid === 1'b1)
			begin
				if (due_q.size() == 0)
					fail_run("out_valid went high with no operation in flight");
				else if (due_q[0] != neg_count)
					fail_run($sformatf("out_valid came %0d cycles early",
						due_q[0] - neg_count));
				else
				begin
					check_result(result, exp_res_q.pop_front(), exp_op_q.pop_front());
					check_flag("nan", nan, exp_nan_q.pop_front());
					check_flag("snan", snan, exp_snan_q.pop_front());
					due_q.delete(0);
				end
			end
			else if (out_valid !== 1'b0)
				fail_run("out_valid is unknown after reset");
			else if (due_q.size() != 0 && due_q[0] <= neg_count)
				fail_run("out_valid did not rise two cycles after in_valid");
		end
	end

	// watchdog, sized from the number of vector rows
	initial
	begin
		wait (num_rows > 0);
		#((num_rows + 20) * clk_period_ns);
		fail_run("timeout: the run did not finish in time");
	end

endmodule

`default_nettype wire

//--- compile.f
verilog/fp16_pkg.sv
verilog/fp16_decomp.sv
verilog/fp16_compare.sv
verilog/fp16_minmax.sv
verilog/fp16_cmp_unit.sv
dv/fp16_clk_gen.sv
dv/tb_fp16_cmp_unit.sv

//--- Bender.yml
package:
  name: fp16_cmp_unit

sources:
  # design, in compile order
  - verilog/fp16_pkg.sv
  - verilog/fp16_decomp.sv
  - verilog/fp16_compare.sv
  - verilog/fp16_minmax.sv
  - verilog/fp16_cmp_unit.sv

  # testbench
  - target: test
    files:
      - dv/fp16_clk_gen.sv
      - dv/tb_fp16_cmp_unit.sv

//--- dv/fp16_cmp_input.txt
// valid op a b result nan snan, all hex, one operation per row
// op 0 cmp 1 eq 2 lt 3 le 4 un 5 min 6 max, valid 0 marks an idle cycle
0 0 0000 0000 0000 0 0
1 0 3c00 4000 110e 0 0
1 0 4000 3c00 1f00 0 0
1 0 3c00 3c00 1a05 0 0
1 0 bc00 3c00 1906 0 0
1 0 c000 bc00 1906 0 0
1 0 bc00 c000 1708 0 0
1 0 0000 8000 1a05 0 0
1 0 3800 c000 1708 0 0
1 0 fc00 7c00 1906 0 0
1 0 7c00 7c00 1a05 0 0
1 0 7e00 3c00 0f10 1 0
1 0 3c00 7c01 0718 1 1
0 0 0000 0000 0000 0 0
1 1 0000 8000 0001 0 0
1 2 8000 0000 0000 0 0
1 3 8000 0000 0001 0 0
1 1 3c00 bc00 0000 0 0
1 2 bc00 3c00 0001 0 0
1 4 3c00 4000 0000 0 0
1 4 7e00 3c00 0001 1 0
1 1 7e00 7e00 0000 1 0
1 2 3c00 fe00 0000 1 0
1 3 7d00 3c00 0000 1 1
1 4 7c01 7e00 0001 1 1
0 0 0000 0000 0000 0 0
0 0 0000 0000 0000 0 0
1 5 3c00 4000 3c00 0 0
1 6 3c00 4000 4000 0 0
1 5 c000 3800 c000 0 0
1 5 bc00 c000 c000 0 0
1 5 7e00 3c00 3c00 1 0
1 6 3c00 7e00 3c00 1 0
1 5 7c01 4000 4000 1 1
1 5 7e00 7c01 7e00 1 1
1 6 fe00 7e55 7e00 1 0
1 5 0000 8000 8000 0 0
1 6 0000 8000 0000 0 0
1 5 3c00 3c00 3c00 0 0
0 0 0000 0000 0000 0 0
